/* bench/tb_i3c_target.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the I3C target controller
// Bus agent tasks, RX/TX FIFO models, reference counts
// and 40 random transfers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "i3c_tgt_cfg.svh"

module tb_i3c_target
  import i3c_tgt_pkg::*;
();

  logic        clk = 1'b0;
  logic        rst_n;
  logic        enable;
  bus_evt_t    bus_evt;
  bus_rsp_t    bus_rsp;
  bus_req_t    bus_req;
  addr_cfg_t   addr_cfg;
  rx_fifo_wr_t rx_fifo;
  logic        wready;
  logic        tx_rvalid;
  data_t       tx_rdata;
  logic        tx_last;
  logic        tx_rready;
  ccc_t        ccc;
  logic        ccc_valid;
  logic        ccc_done;
  data_t       last_addr;
  logic        last_addr_valid;
  logic        idle;
  logic        transmitting;
  logic        nack;
  logic        perr;
  logic        ovf;

  int    seed = 32'h9b5e1a87;
  addr_t own;
  addr_t sta;
  logic  both_valid;
  logic  pending_start;
  // TX FIFO model, circular over 256 entries
  data_t tx_mem [256];
  logic [7:0] tx_rd;
  logic [7:0] tx_end;
  // Observed activity, counted at the falling edge
  data_t got_wr [$];
  data_t exp_wr [$];
  int last_cnt, nack_cnt, perr_cnt, ovf_cnt, tx_req_cnt;
  int exp_last, exp_nack, exp_perr, exp_ovf;
  string names [6] = '{"rx_bit", "rx_byte", "tx_bit", "tx_byte", "ccc_valid", "idle"};

  always #20 clk = ~clk;

  i3c_target u_i3c_target (
    .clk_i(clk), .rst_ni(rst_n), .target_enable_i(enable),
    .bus_evt_i(bus_evt), .bus_rsp_i(bus_rsp), .bus_req_o(bus_req),
    .addr_cfg_i(addr_cfg), .rx_fifo_o(rx_fifo), .rx_fifo_wready_i(wready),
    .tx_fifo_rvalid_i(tx_rvalid), .tx_fifo_rdata_i(tx_rdata),
    .tx_last_byte_i(tx_last), .tx_fifo_rready_o(tx_rready),
    .ccc_o(ccc), .ccc_valid_o(ccc_valid), .ccc_done_i(ccc_done),
    .last_addr_o(last_addr), .last_addr_valid_o(last_addr_valid),
    .target_idle_o(idle), .target_transmitting_o(transmitting),
    .event_target_nack_o(nack), .parity_err_o(perr), .rx_overflow_err_o(ovf)
  );

  assign tx_rdata  = tx_mem[tx_rd];
  assign tx_rvalid = (tx_rd != tx_end);
  assign tx_last   = (tx_rd == tx_end - 8'd1);

  // Pop on the edge that ends the rready cycle
  always @(posedge clk) begin
    if (tx_rready) tx_rd <= tx_rd + 8'd1;
  end

  always @(negedge clk) begin
    if (rst_n) begin
      if (rx_fifo.wvalid) got_wr.push_back(rx_fifo.wdata);
      if (rx_fifo.last) last_cnt++;
      if (nack) nack_cnt++;
      if (perr) perr_cnt++;
      if (ovf) ovf_cnt++;
      if (bus_req.tx_bit || bus_req.tx_byte) tx_req_cnt++;
    end
  end

  function automatic int unsigned rnd(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic sig_of(int sel);
    case (sel)
      0: return bus_req.rx_bit;
      1: return bus_req.rx_byte;
      2: return bus_req.tx_bit;
      3: return bus_req.tx_byte;
      4: return ccc_valid;
      default: return idle;
    endcase
  endfunction

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_eq(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic wait_for(int sel);
    int n;
    n = 0;
    @(negedge clk);
    while (!sig_of(sel)) begin
      n++;
      if (n > 200) fail_run($sformatf("Timeout while waiting for %s", names[sel]));
      @(negedge clk);
    end
  endtask

  // Done pulse 1 to 4 cycles after the request
  task automatic give_rx(data_t d);
    repeat (1 + rnd(4)) @(posedge clk);
    bus_rsp.rx_done <= 1'b1;
    bus_rsp.rx_data <= d;
    @(posedge clk);
    bus_rsp.rx_done <= 1'b0;
  endtask

  task automatic give_tx();
    repeat (1 + rnd(4)) @(posedge clk);
    bus_rsp.tx_done <= 1'b1;
    @(posedge clk);
    bus_rsp.tx_done <= 1'b0;
  endtask

  task automatic pulse_evt(logic [2:0] e);
    @(posedge clk);
    bus_evt <= bus_evt_t'(e);
    @(posedge clk);
    bus_evt <= '0;
  endtask

  task automatic begin_xfer();
    if (!pending_start) pulse_evt(3'b100);
    pending_start = 1'b0;
  endtask

  // ACK is a T-bit request with value zero, driven by the target
  task automatic ack_phase();
    wait_for(2);
    check_eq("bus_req_o.tx_value", bus_req.tx_value, 8'h00);
    check_eq("target_transmitting_o", transmitting, 1);
    give_tx();
  endtask

  task automatic write_body();
    int   n;
    int   bad_at;
    int   i;
    logic rdy [4];
    logic perr_seen;
    logic nxt;
    data_t d;
    n = 1 + rnd(4);
    bad_at = (rnd(6) == 0) ? int'(rnd(n)) : -1;
    perr_seen = 1'b0;
    for (i = 0; i < 4; i++) rdy[i] = (rnd(5) != 0);
    // FIFO space is sampled when each byte phase starts
    @(posedge clk);
    wready <= rdy[0];
    ack_phase();
    check_eq("last_addr_o", last_addr, {own, 1'b0});
    check_eq("last_addr_valid_o", last_addr_valid, 1);
    for (i = 0; i < n; i++) begin
      d = data_t'(rnd(256));
      wait_for(1);
      // Host drives the data byte
      check_eq("target_transmitting_o", transmitting, 0);
      give_rx(d);
      wait_for(0);
      nxt = (i + 1 < n) ? rdy[i+1] : 1'b1;
      @(posedge clk);
      wready <= nxt;
      if (!rdy[i]) exp_ovf++;
      if (i == bad_at) begin
        exp_perr++;
        perr_seen = 1'b1;
        give_rx({7'd0, ^d});
      end else begin
        if (!perr_seen && rdy[i]) exp_wr.push_back(d);
        give_rx({7'd0, ~^d});
      end
    end
    wait_for(1);
    exp_last++;
    if (rnd(2) == 0) begin
      pulse_evt(3'b001);
    end else begin
      pulse_evt(3'b100);
      pending_start = 1'b1;
    end
    check_eq("rx write count", got_wr.size(), exp_wr.size());
    while (exp_wr.size() > 0) check_eq("rx_fifo_o.wdata", got_wr.pop_front(), exp_wr.pop_front());
  endtask

  task automatic read_body();
    int         len;
    int         i;
    logic [7:0] base;
    len = 1 + rnd(4);
    base = tx_rd;
    @(posedge clk);
    for (i = 0; i < len; i++) tx_mem[base + 8'(i)] <= data_t'(rnd(256));
    tx_end <= base + 8'(len);
    ack_phase();
    check_eq("last_addr_o", last_addr, {own, 1'b1});
    for (i = 0; i < len; i++) begin
      wait_for(3);
      check_eq("bus_req_o.tx_value", bus_req.tx_value, tx_mem[base + 8'(i)]);
      give_tx();
      wait_for(2);
      check_eq("bus_req_o.tx_value", bus_req.tx_value, (i == len - 1) ? 0 : 1);
      give_tx();
    end
    check_eq("tx_fifo_rready_o pops", tx_rd - base, len);
    // Finished read also passes through Wait
    exp_nack++;
    pulse_evt(3'b001);
  endtask

  task automatic mismatch_xfer();
    addr_t a;
    int    req_before;
    logic [7:0] rd_before;
    if (both_valid && rnd(2) == 0) begin
      a = sta;
    end else begin
      do a = addr_t'(rnd(128)); while (a == own || a == 7'h7E);
    end
    begin_xfer();
    wait_for(1);
    req_before = tx_req_cnt;
    rd_before = tx_rd;
    give_rx({a, 1'(rnd(2))});
    // One check cycle, then Wait
    repeat (2) @(posedge clk);
    pulse_evt(3'b001);
    exp_nack++;
    check_eq("tx request cycles", tx_req_cnt, req_before);
    check_eq("tx_fifo_rready_o pops", tx_rd, rd_before);
    check_eq("rx write count", got_wr.size(), 0);
  endtask

  task automatic ccc_xfer();
    ccc_t code;
    int   k;
    int   hold;
    code = ccc_t'(rnd(256));
    begin_xfer();
    wait_for(1);
    give_rx(`I3C_RSVD_BYTE);
    ack_phase();
    wait_for(1);
    give_rx(code);
    wait_for(4);
    check_eq("ccc_o", ccc, code);
    hold = int'(rnd(5));
    for (k = 0; k < hold; k++) begin
      @(negedge clk);
      check_eq("ccc_valid_o", ccc_valid, 1);
    end
    @(posedge clk);
    ccc_done <= 1'b1;
    @(posedge clk);
    ccc_done <= 1'b0;
    wait_for(5);
  endtask

  task automatic pick_cfg();
    int    mode;
    addr_t dyn;
    mode = rnd(3);
    do dyn = addr_t'(rnd(128)); while (dyn == 7'h7E);
    do sta = addr_t'(rnd(128)); while (sta == 7'h7E || sta == dyn);
    both_valid = (mode == 2);
    own = (mode != 1) ? dyn : sta;
    @(posedge clk);
    addr_cfg <= '{sta_addr: sta, sta_valid: (mode != 0), dyn_addr: dyn, dyn_valid: (mode != 1)};
  endtask

  task automatic compare_counts();
    check_eq("rx_fifo_o.last pulses", last_cnt, exp_last);
    check_eq("event_target_nack_o pulses", nack_cnt, exp_nack);
    check_eq("parity_err_o pulses", perr_cnt, exp_perr);
    check_eq("rx_overflow_err_o pulses", ovf_cnt, exp_ovf);
  endtask

  initial begin
    int   t;
    logic rnw;
    rst_n = 1'b0;
    enable = 1'b0;
    bus_evt = '0;
    bus_rsp = '0;
    addr_cfg = '0;
    wready = 1'b1;
    ccc_done = 1'b0;
    tx_rd = '0;
    tx_end = '0;
    pending_start = 1'b0;
    for (t = 0; t < 256; t++) tx_mem[t] = data_t'(t) ^ 8'h5A;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    enable <= 1'b1;
    @(negedge clk);
    check_eq("target_idle_o", idle, 1);
    check_eq("ccc_o", ccc, 0);
    check_eq("last_addr_o", last_addr, 0);
    for (t = 0; t < 40; t++) begin
      pick_cfg();
      case (rnd(6))
        0, 1: begin
          begin_xfer();
          wait_for(1);
          give_rx({own, 1'b0});
          write_body();
        end
        2: begin
          begin_xfer();
          wait_for(1);
          give_rx({own, 1'b1});
          read_body();
        end
        3: mismatch_xfer();
        4: ccc_xfer();
        default: begin
          // Broadcast, then repeated START to the own address
          begin_xfer();
          wait_for(1);
          give_rx(`I3C_RSVD_BYTE);
          ack_phase();
          wait_for(1);
          pulse_evt(3'b010);
          wait_for(1);
          rnw = 1'(rnd(2));
          give_rx({own, rnw});
          if (rnw) read_body();
          else write_body();
        end
      endcase
      compare_counts();
    end
    // A write that ended on START still needs its address
    if (pending_start) begin
      mismatch_xfer();
      compare_counts();
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* common/i3c_tgt_cfg.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Width macros and the reserved broadcast byte for the
// I3C target transfer controller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef I3C_TGT_CFG_SVH
`define I3C_TGT_CFG_SVH

// One SDR data byte on the bus
`define I3C_DATA_W 8

// Static and dynamic target addresses
`define I3C_ADDR_W 7

// Broadcast address 7E with the write bit
`define I3C_RSVD_BYTE 8'hFC

`endif

/* common/i3c_tgt_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the I3C target controller
// Vector typedefs, FSM state enum, bus and FIFO structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "i3c_tgt_cfg.svh"

package i3c_tgt_pkg;

  typedef logic [`I3C_DATA_W-1:0] data_t;
  typedef logic [`I3C_ADDR_W-1:0] addr_t;
  typedef logic [`I3C_DATA_W-1:0] ccc_t;

  // Primary FSM states
  typedef enum logic [3:0] {
    Idle,
    RxFByte,
    CheckFByte,
    TxAckFByte,
    RxSByte,
    RxSByteRepeated,
    CheckSByte,
    TxAckSByte,
    RxPWriteData,
    RxPWriteTbit,
    TxPReadData,
    TxPReadTbit,
    Wait,
    DoCCC,
    DoneCCC
  } tgt_state_e;

  // One-cycle pulses from the bus monitor
  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
  } bus_evt_t;

  // Level requests towards the bit/byte bus layer
  typedef struct packed {
    logic  rx_bit;
    logic  rx_byte;
    logic  tx_bit;
    logic  tx_byte;
    data_t tx_value;
  } bus_req_t;

  // Done pulses and received data from the bus layer
  typedef struct packed {
    logic  tx_done;
    logic  rx_done;
    data_t rx_data;
  } bus_rsp_t;

  typedef struct packed {
    addr_t sta_addr;
    logic  sta_valid;
    addr_t dyn_addr;
    logic  dyn_valid;
  } addr_cfg_t;

  typedef struct packed {
    logic  wvalid;
    data_t wdata;
    logic  last;
  } rx_fifo_wr_t;

  // Strobes from the FSM to the datapath blocks
  typedef struct packed {
    logic addr_capture;
    logic ccc_capture;
    logic wr_start;
    logic wr_byte_done;
    logic wr_tbit_done;
    logic wr_exit;
    logic rd_load;
    logic rd_tbit;
    logic xfer_start;
    logic idle;
  } tgt_ctrl_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run the I3C target testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_i3c_target -f src.f

out="$(./obj_dir/Vtb_i3c_target)" || { echo "$out"; exit 1; }
echo "$out"
echo "$out" | grep -q "Test completed successfully"

/* source/addr_decoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address byte capture, CCC code latch and
// dynamic/static/broadcast address matching
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "i3c_tgt_cfg.svh"

module addr_decoder
  import i3c_tgt_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  tgt_ctrl_t ctrl_i,
  input  bus_rsp_t  bus_rsp_i,
  input  addr_cfg_t addr_cfg_i,
  output logic      addr_match_o,
  output logic      rsvd_match_o,
  output logic      last_addr_valid_o,
  output data_t     last_addr_o,
  output ccc_t      ccc_o
);

  addr_t addr_q;
  logic  rnw_q;

  // Address and R/nW bit of the last received address byte
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
      rnw_q  <= 1'b0;
    end else if (ctrl_i.addr_capture) begin
      addr_q <= bus_rsp_i.rx_data[`I3C_DATA_W-1:1];
      rnw_q  <= bus_rsp_i.rx_data[0];
    end else if (ctrl_i.idle) begin
      addr_q <= '0;
      rnw_q  <= 1'b0;
    end
  end

  assign last_addr_o = {addr_q, rnw_q};

  // Valid from the capture until the next start
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_addr_valid_o <= 1'b0;
    end else if (ctrl_i.xfer_start) begin
      last_addr_valid_o <= 1'b0;
    end else if (ctrl_i.addr_capture) begin
      last_addr_valid_o <= 1'b1;
    end
  end

  // Command code for the external CCC engine
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ccc_o <= '0;
    end else if (ctrl_i.ccc_capture) begin
      ccc_o <= bus_rsp_i.rx_data;
    end
  end

  // Dynamic address wins when assigned
  assign addr_match_o = addr_cfg_i.dyn_valid ? (addr_cfg_i.dyn_addr == addr_q) :
                        addr_cfg_i.sta_valid ? (addr_cfg_i.sta_addr == addr_q) :
                        1'b0;
  // Broadcast 7E with write bit
  assign rsvd_match_o = (last_addr_o == `I3C_RSVD_BYTE);

  a_ccc_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !ctrl_i.ccc_capture |=> $stable(ccc_o));

endmodule

/* source/i3c_target.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I3C target transfer controller, top level
// Primary FSM plus address, RX and TX datapaths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module i3c_target
  import i3c_tgt_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        target_enable_i,
  input  bus_evt_t    bus_evt_i,
  input  bus_rsp_t    bus_rsp_i,
  output bus_req_t    bus_req_o,
  input  addr_cfg_t   addr_cfg_i,
  output rx_fifo_wr_t rx_fifo_o,
  input  logic        rx_fifo_wready_i,
  input  logic        tx_fifo_rvalid_i,
  input  data_t       tx_fifo_rdata_i,
  input  logic        tx_last_byte_i,
  output logic        tx_fifo_rready_o,
  output ccc_t        ccc_o,
  output logic        ccc_valid_o,
  input  logic        ccc_done_i,
  output data_t       last_addr_o,
  output logic        last_addr_valid_o,
  output logic        target_idle_o,
  output logic        target_transmitting_o,
  output logic        event_target_nack_o,
  output logic        parity_err_o,
  output logic        rx_overflow_err_o
);

  tgt_ctrl_t ctrl;
  logic      addr_match;
  logic      rsvd_match;
  logic      tx_end_xfer;
  logic      rx_bit;
  logic      rx_byte;
  logic      tx_bit;
  logic      tx_byte;
  data_t     tx_value;

  // Request flags from the FSM, value from the TX datapath
  assign bus_req_o = '{rx_bit: rx_bit, rx_byte: rx_byte, tx_bit: tx_bit,
                       tx_byte: tx_byte, tx_value: tx_value};

  tgt_fsm u_tgt_fsm (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .enable_i              (target_enable_i),
    .bus_evt_i             (bus_evt_i),
    .bus_rsp_i             (bus_rsp_i),
    .addr_match_i          (addr_match),
    .rsvd_match_i          (rsvd_match),
    .tx_fifo_rvalid_i      (tx_fifo_rvalid_i),
    .tx_end_xfer_i         (tx_end_xfer),
    .ccc_done_i            (ccc_done_i),
    .ctrl_o                (ctrl),
    .rx_bit_o              (rx_bit),
    .rx_byte_o             (rx_byte),
    .tx_bit_o              (tx_bit),
    .tx_byte_o             (tx_byte),
    .ccc_valid_o           (ccc_valid_o),
    .target_idle_o         (target_idle_o),
    .target_transmitting_o (target_transmitting_o),
    .event_target_nack_o   (event_target_nack_o)
  );

  addr_decoder u_addr_decoder (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .ctrl_i            (ctrl),
    .bus_rsp_i         (bus_rsp_i),
    .addr_cfg_i        (addr_cfg_i),
    .addr_match_o      (addr_match),
    .rsvd_match_o      (rsvd_match),
    .last_addr_valid_o (last_addr_valid_o),
    .last_addr_o       (last_addr_o),
    .ccc_o             (ccc_o)
  );

  rx_datapath u_rx_datapath (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .ctrl_i            (ctrl),
    .bus_rsp_i         (bus_rsp_i),
    .rx_fifo_wready_i  (rx_fifo_wready_i),
    .rx_fifo_o         (rx_fifo_o),
    .parity_err_o      (parity_err_o),
    .rx_overflow_err_o (rx_overflow_err_o)
  );

  tx_datapath u_tx_datapath (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .ctrl_i           (ctrl),
    .tx_fifo_rdata_i  (tx_fifo_rdata_i),
    .tx_last_byte_i   (tx_last_byte_i),
    .tx_fifo_rready_o (tx_fifo_rready_o),
    .tx_end_xfer_o    (tx_end_xfer),
    .tx_value_o       (tx_value)
  );

endmodule

/* source/rx_datapath.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Private write datapath
// Byte hold, T-bit parity, overflow and RX FIFO write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module rx_datapath
  import i3c_tgt_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  tgt_ctrl_t   ctrl_i,
  input  bus_rsp_t    bus_rsp_i,
  input  logic        rx_fifo_wready_i,
  output rx_fifo_wr_t rx_fifo_o,
  output logic        parity_err_o,
  output logic        rx_overflow_err_o
);

  data_t data_q;
  logic  parity_q;
  logic  ovf_q;
  logic  ovf_pulse_q;
  logic  tbit_bad;

  // Payload byte, written to the FIFO after its T-bit
  always_ff @(posedge clk_i) begin
    if (ctrl_i.wr_byte_done) begin
      data_q <= bus_rsp_i.rx_data;
    end
  end

  // T-bit is odd parity over the byte
  assign tbit_bad     = bus_rsp_i.rx_data[0] != ~^data_q;
  assign parity_err_o = ctrl_i.wr_tbit_done & tbit_bad;

  // Sticky until the next start or Idle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      parity_q <= 1'b0;
    end else if (ctrl_i.xfer_start || ctrl_i.idle) begin
      parity_q <= 1'b0;
    end else if (parity_err_o) begin
      parity_q <= 1'b1;
    end
  end

  // Overflow sampled at every byte start, pulse one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ovf_q       <= 1'b0;
      ovf_pulse_q <= 1'b0;
    end else begin
      ovf_pulse_q <= ctrl_i.wr_start & ~rx_fifo_wready_i;
      if (ctrl_i.wr_start) begin
        ovf_q <= ~rx_fifo_wready_i;
      end else if (ctrl_i.xfer_start || ctrl_i.idle) begin
        ovf_q <= 1'b0;
      end
    end
  end

  assign rx_overflow_err_o = ovf_pulse_q;

  // FIFO write in the T-bit done cycle
  assign rx_fifo_o.wvalid = ctrl_i.wr_tbit_done & ~tbit_bad & ~parity_q & ~ovf_q;
  assign rx_fifo_o.wdata  = data_q;
  assign rx_fifo_o.last   = ctrl_i.wr_exit;

  // No write after a parity error for the rest of the transfer
  a_parity_block: assert property (@(posedge clk_i) disable iff (!rst_ni)
    parity_err_o |=> !rx_fifo_o.wvalid until (ctrl_i.xfer_start || ctrl_i.idle));

endmodule

/* source/tx_datapath.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Private read datapath
// TX FIFO pop, last-byte tracking, bus value select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "i3c_tgt_cfg.svh"

module tx_datapath
  import i3c_tgt_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  tgt_ctrl_t ctrl_i,
  input  data_t     tx_fifo_rdata_i,
  input  logic      tx_last_byte_i,
  output logic      tx_fifo_rready_o,
  output logic      tx_end_xfer_o,
  output data_t     tx_value_o
);

  data_t byte_q;
  logic  last_q;
  logic  rd_active_q;

  // Pop on entry to the read data phase
  assign tx_fifo_rready_o = ctrl_i.rd_load;

  always_ff @(posedge clk_i) begin
    if (ctrl_i.rd_load) begin
      byte_q <= tx_fifo_rdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q <= 1'b0;
    end else if (ctrl_i.rd_load) begin
      last_q <= tx_last_byte_i;
    end
  end

  assign tx_end_xfer_o = last_q;

  // Set while a private read owns the bus value
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_active_q <= 1'b0;
    end else if (ctrl_i.xfer_start || ctrl_i.idle) begin
      rd_active_q <= 1'b0;
    end else if (ctrl_i.rd_load) begin
      rd_active_q <= 1'b1;
    end
  end

  // T-bit is 1 for more data, 0 after the last byte
  // ACK outside a read drives zero
  always_comb begin
    if (ctrl_i.rd_tbit) begin
      tx_value_o = {{(`I3C_DATA_W-1){1'b0}}, ~last_q};
    end else if (rd_active_q) begin
      tx_value_o = byte_q;
    end else begin
      tx_value_o = '0;
    end
  end

endmodule

/* src.f */
+incdir+common
common/i3c_tgt_pkg.sv
source/addr_decoder.sv
source/rx_datapath.sv
source/tx_datapath.sv
tgt_fsm/tgt_fsm.sv
source/i3c_target.sv
bench/tb_i3c_target.sv

/* tgt_fsm/tgt_fsm.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Primary transfer FSM of the I3C target
// Address, ACK, private write/read and CCC hand-off phases
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tgt_fsm
  import i3c_tgt_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      enable_i,
  input  bus_evt_t  bus_evt_i,
  input  bus_rsp_t  bus_rsp_i,
  input  logic      addr_match_i,
  input  logic      rsvd_match_i,
  input  logic      tx_fifo_rvalid_i,
  input  logic      tx_end_xfer_i,
  input  logic      ccc_done_i,
  output tgt_ctrl_t ctrl_o,
  output logic      rx_bit_o,
  output logic      rx_byte_o,
  output logic      tx_bit_o,
  output logic      tx_byte_o,
  output logic      ccc_valid_o,
  output logic      target_idle_o,
  output logic      target_transmitting_o,
  output logic      event_target_nack_o
);

  tgt_state_e state_q, state_d;
  logic       bus_start;
  logic       rnw_q;

  // START and repeated START are handled alike
  assign bus_start = bus_evt_i.start | bus_evt_i.rstart;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (enable_i && bus_start) state_d = RxFByte;
      end
      RxFByte: begin
        if (bus_rsp_i.rx_done) state_d = CheckFByte;
      end
      // Match flags are valid one cycle after the capture
      CheckFByte: begin
        state_d = (addr_match_i || rsvd_match_i) ? TxAckFByte : Wait;
      end
      TxAckFByte: begin
        if (bus_rsp_i.tx_done) begin
          if (rsvd_match_i) state_d = RxSByte;
          else state_d = rnw_q ? TxPReadData : RxPWriteData;
        end
      end
      // Broadcast seen, either a command byte or a repeated START
      RxSByte: begin
        if (bus_start) state_d = RxSByteRepeated;
        else if (bus_evt_i.stop) state_d = Idle;
        else if (bus_rsp_i.rx_done) state_d = DoCCC;
      end
      RxSByteRepeated: begin
        if (bus_rsp_i.rx_done) state_d = CheckSByte;
      end
      CheckSByte: begin
        state_d = addr_match_i ? TxAckSByte : Wait;
      end
      TxAckSByte: begin
        if (bus_rsp_i.tx_done) state_d = rnw_q ? TxPReadData : RxPWriteData;
      end
      // Private write loop
      RxPWriteData: begin
        if (bus_start) state_d = RxFByte;
        else if (bus_evt_i.stop) state_d = Idle;
        else if (bus_rsp_i.rx_done) state_d = RxPWriteTbit;
      end
      RxPWriteTbit: begin
        if (bus_rsp_i.rx_done) state_d = RxPWriteData;
      end
      // Private read loop
      TxPReadData: begin
        if (bus_start) state_d = RxFByte;
        else if (bus_evt_i.stop) state_d = Idle;
        else if (bus_rsp_i.tx_done) state_d = TxPReadTbit;
      end
      TxPReadTbit: begin
        if (bus_start) state_d = RxFByte;
        else if (bus_evt_i.stop) state_d = Idle;
        else if (bus_rsp_i.tx_done) begin
          // Keep reading while more bytes are queued
          state_d = (!tx_end_xfer_i && tx_fifo_rvalid_i) ? TxPReadData : Wait;
        end
      end
      // Not for us, or read finished
      Wait: begin
        if (bus_start) state_d = RxFByte;
        else if (bus_evt_i.stop) state_d = Idle;
      end
      DoCCC: begin
        if (ccc_done_i) state_d = DoneCCC;
      end
      DoneCCC: state_d = Idle;
      default: state_d = Idle;
    endcase
  end

  // Local copy of the R/nW bit, loaded with the address byte
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rnw_q <= 1'b0;
    end else if (ctrl_o.addr_capture) begin
      rnw_q <= bus_rsp_i.rx_data[0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Byte requests are dropped while a start is on the bus
  assign rx_byte_o = (state_q inside {RxFByte, RxSByte, RxSByteRepeated, RxPWriteData})
                     & ~bus_start;
  assign rx_bit_o  = (state_q == RxPWriteTbit);
  assign tx_bit_o  = (state_q inside {TxAckFByte, TxAckSByte, TxPReadTbit});
  assign tx_byte_o = (state_q == TxPReadData) & ~bus_start;

  // Datapath strobes
  assign ctrl_o.addr_capture = bus_rsp_i.rx_done
                               & (state_q inside {RxFByte, RxSByte, RxSByteRepeated});
  assign ctrl_o.ccc_capture  = bus_rsp_i.rx_done & (state_q == RxSByte);
  assign ctrl_o.wr_start     = (state_d == RxPWriteData) & (state_q != RxPWriteData);
  assign ctrl_o.wr_byte_done = bus_rsp_i.rx_done & (state_q == RxPWriteData);
  assign ctrl_o.wr_tbit_done = bus_rsp_i.rx_done & (state_q == RxPWriteTbit);
  assign ctrl_o.wr_exit      = (state_q == RxPWriteData) & (bus_start | bus_evt_i.stop);
  assign ctrl_o.rd_load      = (state_d == TxPReadData) & (state_q != TxPReadData);
  assign ctrl_o.rd_tbit      = (state_q == TxPReadTbit);
  assign ctrl_o.xfer_start   = bus_start;
  assign ctrl_o.idle         = (state_q == Idle);

  // Status and events
  assign ccc_valid_o           = (state_q == DoCCC);
  assign target_idle_o         = (state_q == Idle);
  assign target_transmitting_o = (state_q inside {TxAckFByte, TxAckSByte,
                                                  TxPReadData, TxPReadTbit});
  // One NACK count per refused or finished transfer
  assign event_target_nack_o   = (state_d == Wait) & (state_q != Wait);

  // Bus layer accepts one request at a time
  a_one_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({rx_bit_o, rx_byte_o, tx_bit_o, tx_byte_o}));

  // CCC hand-off holds until done, then one DoneCCC cycle before Idle
  a_ccc_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ccc_valid_o && !ccc_done_i |=> ccc_valid_o);
  a_ccc_exit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ccc_valid_o && ccc_done_i |=> state_q == DoneCCC ##1 target_idle_o);

endmodule
